/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int XLEN    = 32;
    localparam int REG_NUM = 32;
    localparam int REG_AW  = $clog2(REG_NUM);

    // Major opcodes, bits [6:0] of the instruction
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Immediate formats
    localparam logic [1:0] IMM_I = 2'b00;
    localparam logic [1:0] IMM_B = 2'b01;
    localparam logic [1:0] IMM_S = 2'b10;
    localparam logic [1:0] IMM_J = 2'b11;

    // Next-pc source seen by fetch
    localparam logic [1:0] PC_SEQ    = 2'b00; // Plain pc + 4
    localparam logic [1:0] PC_BRANCH = 2'b01;
    localparam logic [1:0] PC_JAL    = 2'b10;
    localparam logic [1:0] PC_JALR   = 2'b11;

    // Register view, also carries the S and B immediate bits
    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    // Immediate view of the same word
    typedef struct packed {
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic [4:0] alu_op;
        logic       has_imm;   // op_b takes the immediate
        logic [1:0] imm_type;
        logic [1:0] pc_sel;
        logic       is_load;
        logic       is_branch;
    } ctrl_t;

    // Result offered for bypass by a later stage
    typedef struct packed {
        logic              valid;
        logic              is_load; // Data not ready until after memory
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } fwd_t;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   op_b;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
    } idex_t;

    typedef struct packed {
        logic            valid;
        logic [1:0]      pc_sel;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* verilog/control_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    input  wire cpu_pkg::inst_t          inst,
    output cpu_pkg::ctrl_t               ctrl,
    output logic [cpu_pkg::XLEN-1:0]     imm
);

    logic [cpu_pkg::XLEN-1:0] imm_i;
    logic [cpu_pkg::XLEN-1:0] imm_s;
    logic [cpu_pkg::XLEN-1:0] imm_b;
    logic [cpu_pkg::XLEN-1:0] imm_j;

    // Opcode to control word, unknown opcodes leave everything clear
    always_comb begin
        ctrl = '0;
        case (inst.r.opcode)
            cpu_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = {inst.r.funct7[5], inst.r.funct3, 1'b0}; // Bit 30 picks sub/sra
            end
            cpu_pkg::OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.has_imm   = 1'b1;
                ctrl.imm_type  = cpu_pkg::IMM_I;
                ctrl.alu_op    = {1'b0, inst.i.funct3, 1'b0};
            end
            cpu_pkg::OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.has_imm   = 1'b1;
                ctrl.imm_type  = cpu_pkg::IMM_I;
                ctrl.is_load   = 1'b1;
            end
            cpu_pkg::OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.has_imm   = 1'b1;
                ctrl.imm_type  = cpu_pkg::IMM_S;
            end
            cpu_pkg::OPC_BRANCH: begin
                ctrl.alu_op    = 5'b01111; // Equality compare
                ctrl.imm_type  = cpu_pkg::IMM_B;
                ctrl.pc_sel    = cpu_pkg::PC_BRANCH;
                ctrl.is_branch = 1'b1;
            end
            cpu_pkg::OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_type  = cpu_pkg::IMM_J;
                ctrl.pc_sel    = cpu_pkg::PC_JAL;
            end
            cpu_pkg::OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.has_imm   = 1'b1;
                ctrl.imm_type  = cpu_pkg::IMM_I;
                ctrl.pc_sel    = cpu_pkg::PC_JALR;
            end
            default: ;
        endcase
    end

    // Sign-extended immediates, bit 31 is the sign in every format
    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_s = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rd};
    assign imm_b = {{20{inst.r.funct7[6]}}, inst.r.rd[0], inst.r.funct7[5:0],
                    inst.r.rd[4:1], 1'b0};
    // J format reuses the rs1/funct3 field as imm[19:12]
    assign imm_j = {{12{inst.i.imm12[11]}}, inst.i.rs1, inst.i.funct3,
                    inst.i.imm12[0], inst.i.imm12[10:1], 1'b0};

    always_comb begin
        case (ctrl.imm_type)
            cpu_pkg::IMM_S: imm = imm_s;
            cpu_pkg::IMM_B: imm = imm_b;
            cpu_pkg::IMM_J: imm = imm_j;
            default:        imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [cpu_pkg::REG_AW-1:0]       rs1,
    input  wire [cpu_pkg::REG_AW-1:0]       rs2,
    input  wire cpu_pkg::wb_t               wb,
    input  wire cpu_pkg::fwd_t              ex_fwd,
    input  wire cpu_pkg::fwd_t              mm_fwd,
    output logic [cpu_pkg::XLEN-1:0]        rs1_data,
    output logic [cpu_pkg::XLEN-1:0]        rs2_data,
    output logic                            load_stall
);

    logic [cpu_pkg::XLEN-1:0] regs [cpu_pkg::REG_NUM];

    // Newest value wins, x0 is hardwired
    function automatic logic [cpu_pkg::XLEN-1:0] read_port(
        input logic [cpu_pkg::REG_AW-1:0] idx
    );
        logic [cpu_pkg::XLEN-1:0] val;
        if (idx == '0)
            val = '0;
        else if (ex_fwd.valid && ex_fwd.rd == idx)
            val = ex_fwd.data;
        else if (mm_fwd.valid && mm_fwd.rd == idx)
            val = mm_fwd.data;
        else if (wb.en && wb.rd == idx)
            val = wb.data;  // Write-through in the write cycle
        else
            val = regs[idx];
        return val;
    endfunction

    // Flop-based register file
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::REG_NUM; i++)
                regs[i] <= '0;
        end else if (wb.en && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    // Load result still in flight for one of our sources
    always_comb begin
        load_stall = ex_fwd.valid && ex_fwd.is_load && ex_fwd.rd != '0
                     && (ex_fwd.rd == rs1 || ex_fwd.rd == rs2);
    end

endmodule

`default_nettype wire

/* verilog/id_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module id_issue (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         inst_valid,
    output logic                        inst_ready,
    input  wire [cpu_pkg::XLEN-1:0]     pc,
    input  wire cpu_pkg::inst_t         inst,
    input  wire cpu_pkg::ctrl_t         ctrl,
    input  wire [cpu_pkg::XLEN-1:0]     imm,
    input  wire [cpu_pkg::XLEN-1:0]     rs1_data,
    input  wire [cpu_pkg::XLEN-1:0]     rs2_data,
    input  wire                         load_stall,
    output logic                        idex_valid,
    input  wire                         idex_ready,
    output cpu_pkg::idex_t              idex,
    output cpu_pkg::redirect_t          redirect
);

    logic                     slot_free;
    logic                     accept;
    logic                     taken;
    cpu_pkg::idex_t           idex_next;
    cpu_pkg::redirect_t       redir_next;
    logic                     redir_valid;
    logic [1:0]               redir_pc_sel;
    logic [cpu_pkg::XLEN-1:0] redir_target;

    assign slot_free  = !idex_valid || idex_ready;
    assign inst_ready = slot_free && !load_stall;
    assign accept     = inst_valid && inst_ready;

    assign taken = ctrl.is_branch && (rs1_data == rs2_data);

    always_comb begin
        idex_next.ctrl     = ctrl;
        idex_next.pc       = pc;
        idex_next.rs1_data = rs1_data;
        idex_next.rs2_data = rs2_data;
        idex_next.op_b     = ctrl.has_imm ? imm : rs2_data;
        idex_next.imm      = imm;
        idex_next.rd       = inst.r.rd;
        idex_next.rs1      = inst.r.rs1;
        idex_next.rs2      = inst.r.rs2;
    end

    // Target selection for fetch
    always_comb begin
        redir_next.target = pc + imm;
        case (ctrl.pc_sel)
            cpu_pkg::PC_BRANCH: redir_next.valid = taken;
            cpu_pkg::PC_JAL:    redir_next.valid = 1'b1;
            cpu_pkg::PC_JALR: begin
                redir_next.valid  = 1'b1;
                redir_next.target = (rs1_data + imm) & ~cpu_pkg::XLEN'(1); // Clear bit 0
            end
            default:            redir_next.valid = 1'b0;
        endcase
        redir_next.pc_sel = redir_next.valid ? ctrl.pc_sel : cpu_pkg::PC_SEQ;
    end

    // Valid bits, held under back-pressure
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid  <= 1'b0;
            redir_valid <= 1'b0;
        end else if (accept) begin
            idex_valid  <= 1'b1;
            redir_valid <= redir_next.valid;
        end else if (slot_free) begin
            idex_valid  <= 1'b0;
            redir_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idex         <= idex_next;
            redir_pc_sel <= redir_next.pc_sel;
            redir_target <= redir_next.target;
        end
    end

    assign redirect = '{valid: redir_valid, pc_sel: redir_pc_sel, target: redir_target};

endmodule

`default_nettype wire

/* verilog/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         inst_valid,
    output logic                        inst_ready,
    input  wire cpu_pkg::inst_t         inst,
    input  wire [cpu_pkg::XLEN-1:0]     pc,
    input  wire cpu_pkg::wb_t           wb,
    input  wire cpu_pkg::fwd_t          ex_fwd,
    input  wire cpu_pkg::fwd_t          mm_fwd,
    output logic                        idex_valid,
    input  wire                         idex_ready,
    output cpu_pkg::idex_t              idex,
    output cpu_pkg::redirect_t          redirect
);

    cpu_pkg::ctrl_t           ctrl;
    logic [cpu_pkg::XLEN-1:0] imm;
    logic [cpu_pkg::XLEN-1:0] rs1_data;
    logic [cpu_pkg::XLEN-1:0] rs2_data;
    logic                     load_stall;

    control_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    // Source indices always come from the register view
    operand_fetch u_operands (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (inst.r.rs1),
        .rs2        (inst.r.rs2),
        .wb         (wb),
        .ex_fwd     (ex_fwd),
        .mm_fwd     (mm_fwd),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .load_stall (load_stall)
    );

    id_issue u_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .pc         (pc),
        .inst       (inst),
        .ctrl       (ctrl),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .load_stall (load_stall),
        .idex_valid (idex_valid),
        .idex_ready (idex_ready),
        .idex       (idex),
        .redirect   (redirect)
    );

endmodule

`default_nettype wire

/* tb/decode_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_assertions (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  idex_valid,
    input wire                  idex_ready,
    input wire cpu_pkg::idex_t  idex,
    input wire                  inst_ready,
    input wire cpu_pkg::inst_t  inst,
    input wire cpu_pkg::fwd_t   ex_fwd
);

    logic load_use;

    // Load still in execute writes a source of the offered instruction
    assign load_use = ex_fwd.valid && ex_fwd.is_load && ex_fwd.rd != '0
                      && (ex_fwd.rd == inst.r.rs1 || ex_fwd.rd == inst.r.rs2);

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !idex_valid)
        else $error("idex_valid high during reset");

    // Held item must not change until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        idex_valid && !idex_ready |=> idex_valid && $stable(idex))
        else $error("idex changed under back-pressure");

    a_stall_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        load_use |-> !inst_ready)
        else $error("inst_ready high during load-use hazard");

endmodule

bind decode_top decode_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .idex_valid (idex_valid),
    .idex_ready (idex_ready),
    .idex       (idex),
    .inst_ready (inst_ready),
    .inst       (inst),
    .ex_fwd     (ex_fwd)
);

`default_nettype wire

/* tb/tb_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

    localparam int NUM_TESTS     = 6;
    localparam int INST_PER_TEST = 16;
    localparam int CLK_PERIOD    = 100;
    localparam longint TIMEOUT_NS = longint'(NUM_TESTS) * INST_PER_TEST * 20 * CLK_PERIOD;

    logic clk;
    logic rst_n;
    logic inst_valid;
    logic inst_ready;
    cpu_pkg::inst_t inst;
    logic [cpu_pkg::XLEN-1:0] pc;
    cpu_pkg::wb_t wb;
    cpu_pkg::fwd_t ex_fwd;
    cpu_pkg::fwd_t mm_fwd;
    logic idex_valid;
    logic idex_ready;
    cpu_pkg::idex_t idex;
    cpu_pkg::redirect_t redirect;

    integer seed = 82;
    int errors;
    int n_in;
    int n_out;
    logic random_ready;
    logic [cpu_pkg::XLEN-1:0] model_regs [cpu_pkg::REG_NUM];
    cpu_pkg::idex_t exp_idex_q [$];
    cpu_pkg::redirect_t exp_redir_q [$];

    decode_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .pc         (pc),
        .wb         (wb),
        .ex_fwd     (ex_fwd),
        .mm_fwd     (mm_fwd),
        .idex_valid (idex_valid),
        .idex_ready (idex_ready),
        .idex       (idex),
        .redirect   (redirect)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Newest source wins and x0 reads zero
    function automatic logic [31:0] model_read(input logic [4:0] idx);
        if (idx == 5'd0) return 32'd0;
        if (ex_fwd.valid && ex_fwd.rd == idx) return ex_fwd.data;
        if (mm_fwd.valid && mm_fwd.rd == idx) return mm_fwd.data;
        if (wb.en && wb.rd == idx) return wb.data;
        return model_regs[idx];
    endfunction

    // Expected ID/EX content and redirect for one accepted instruction
    function automatic void expect_decode(input logic [31:0] w, input logic [31:0] ipc,
                                          output cpu_pkg::idex_t e,
                                          output cpu_pkg::redirect_t r);
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        e = '0;
        e.pc = ipc;
        e.rd = w[11:7];
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.rs1_data = model_read(w[19:15]);
        e.rs2_data = model_read(w[24:20]);
        e.imm = imm_i;
        case (w[6:0])
            7'b0110011: begin
                e.ctrl.reg_write = 1;
                e.ctrl.alu_op = {w[30], w[14:12], 1'b0};
            end
            7'b0010011: begin
                e.ctrl.reg_write = 1;
                e.ctrl.has_imm = 1;
                e.ctrl.alu_op = {1'b0, w[14:12], 1'b0};
            end
            7'b0000011: begin
                e.ctrl.reg_write = 1;
                e.ctrl.mem_read = 1;
                e.ctrl.has_imm = 1;
                e.ctrl.is_load = 1;
            end
            7'b0100011: begin
                e.ctrl.mem_write = 1;
                e.ctrl.has_imm = 1;
                e.ctrl.imm_type = cpu_pkg::IMM_S;
                e.imm = imm_s;
            end
            7'b1100011: begin
                e.ctrl.alu_op = 5'b01111;
                e.ctrl.is_branch = 1;
                e.ctrl.imm_type = cpu_pkg::IMM_B;
                e.imm = imm_b;
                e.ctrl.pc_sel = cpu_pkg::PC_BRANCH;
            end
            7'b1101111: begin
                e.ctrl.reg_write = 1;
                e.ctrl.imm_type = cpu_pkg::IMM_J;
                e.imm = imm_j;
                e.ctrl.pc_sel = cpu_pkg::PC_JAL;
            end
            7'b1100111: begin
                e.ctrl.reg_write = 1;
                e.ctrl.has_imm = 1;
                e.ctrl.pc_sel = cpu_pkg::PC_JALR;
            end
            default: ;
        endcase
        e.op_b = e.ctrl.has_imm ? e.imm : e.rs2_data;
        r.valid = (e.ctrl.pc_sel == cpu_pkg::PC_BRANCH) ? (e.rs1_data == e.rs2_data)
                                                         : (e.ctrl.pc_sel != cpu_pkg::PC_SEQ);
        r.pc_sel = r.valid ? e.ctrl.pc_sel : cpu_pkg::PC_SEQ;
        r.target = (e.ctrl.pc_sel == cpu_pkg::PC_JALR) ? ((e.rs1_data + e.imm) & ~32'd1)
                                                       : ipc + e.imm;
    endfunction

    // Compare at the falling edge where everything has settled
    always @(negedge clk) begin
        cpu_pkg::idex_t e;
        cpu_pkg::redirect_t r;
        if (rst_n) begin
            if (idex_valid && idex_ready) begin
                n_out++;
                if (exp_idex_q.size() == 0) begin
                    $display("Unexpected item on idex, nothing was accepted for it");
                    errors++;
                end else begin
                    e = exp_idex_q.pop_front();
                    r = exp_redir_q.pop_front();
                    if (idex !== e) begin
                        $display("[ERROR] idex expected %h got %h", e, idex);
                        errors++;
                    end
                    if (redirect !== r) begin
                        $display("[ERROR] redirect expected %h got %h", r, redirect);
                        errors++;
                    end
                end
            end
            if (inst_valid && inst_ready) begin
                n_in++;
                expect_decode(inst, pc, e, r);
                exp_idex_q.push_back(e);
                exp_redir_q.push_back(r);
            end
            if (wb.en && wb.rd != 5'd0) model_regs[wb.rd] = wb.data; // Lands at next edge
        end
    end

    // Output back-pressure
    always @(posedge clk) begin
        logic [31:0] tmp;
        #1;
        tmp = $random(seed);
        idex_ready = random_ready ? tmp[0] : 1'b1;
    end

    task automatic send(input logic [31:0] w, input logic [31:0] ipc, input cpu_pkg::wb_t w_in,
                        input cpu_pkg::fwd_t ex_in, input cpu_pkg::fwd_t mm_in);
        logic done;
        done = 0;
        @(posedge clk);
        #1;
        inst = w;
        pc = ipc;
        wb = w_in;
        ex_fwd = ex_in;
        mm_fwd = mm_in;
        inst_valid = 1;
        while (!done) begin
            @(negedge clk);
            done = inst_ready;
            @(posedge clk);
            #1;
        end
        inst_valid = 0;
        wb = '0;
        ex_fwd = '0;
        mm_fwd = '0;
    endtask

    function automatic logic [31:0] rand_inst(input logic [6:0] opc);
        logic [31:0] w;
        w = $random(seed);
        return {w[31:7], opc};
    endfunction

    function automatic logic [31:0] with_regs(input logic [31:0] w, input logic [4:0] a,
                                              input logic [4:0] b);
        return {w[31:25], b, a, w[14:0]};
    endfunction

    task automatic finish_test(input int num, input string name, input int err_before);
        while (exp_idex_q.size() != 0 || idex_valid) @(posedge clk);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors");
    endtask

    initial begin
        #TIMEOUT_NS;
        $display("Watchdog expired, a test stopped making progress");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [6:0] opcs [8];
        int e0;
        int out0;
        opcs = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011,
                 7'b1100011, 7'b1101111, 7'b1100111, 7'b1110011};
        clk = 0;
        rst_n = 0;
        inst_valid = 0;
        inst = '0;
        pc = '0;
        wb = '0;
        ex_fwd = '0;
        mm_fwd = '0;
        idex_ready = 1;
        random_ready = 0;
        errors = 0;
        n_in = 0;
        n_out = 0;
        for (int i = 0; i < cpu_pkg::REG_NUM; i++) model_regs[i] = '0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1;

        e0 = errors;
        repeat (3) @(negedge clk);
        if (idex_valid || redirect.valid || n_out != 0) begin
            $display("Outputs not idle after reset");
            errors++;
        end
        finish_test(1, "reset", e0);

        e0 = errors;
        for (int i = 0; i < 16; i++) send(rand_inst(opcs[i % 8]), $random(seed), '0, '0, '0);
        finish_test(2, "decode", e0);

        e0 = errors; // Write back, read back, x0 and same-cycle bypass
        for (int i = 0; i < 4; i++)
            send(32'h13, 32'h100, '{1'b1, 5'(i), 32'hA000_0000 + i}, '0, '0);
        send(with_regs(rand_inst(7'b0110011), 1, 2), 32'h104, '0, '0, '0);
        send(with_regs(rand_inst(7'b0110011), 0, 3), 32'h108, '0, '0, '0);
        send(with_regs(rand_inst(7'b0110011), 7, 1), 32'h10c, '{1'b1, 5'd7, 32'h7777}, '0, '0);
        finish_test(3, "register file", e0);

        e0 = errors;
        send(with_regs(rand_inst(7'b0110011), 3, 3), 32'h200,
             '{1'b1, 5'd3, 32'h33}, '{1'b1, 1'b0, 5'd3, 32'hE3}, '{1'b1, 1'b0, 5'd3, 32'hD3});
        send(with_regs(rand_inst(7'b0110011), 3, 2), 32'h204,
             '{1'b1, 5'd3, 32'h34}, '0, '{1'b1, 1'b0, 5'd3, 32'hD4});
        send(with_regs(rand_inst(7'b0110011), 0, 3), 32'h208,
             '0, '{1'b1, 1'b0, 5'd0, 32'hE0}, '{1'b1, 1'b0, 5'd0, 32'hD0});
        finish_test(4, "bypass priority", e0);

        e0 = errors;
        out0 = n_out;
        fork
            send(with_regs(rand_inst(7'b0110011), 5, 1), 32'h300, '0,
                 '{1'b1, 1'b1, 5'd5, 32'h55}, '0);
            begin
                @(posedge clk);
                repeat (3) begin
                    @(negedge clk);
                    if (inst_ready) begin
                        $display("inst_ready high while a load hazard is pending");
                        errors++;
                    end
                end
                @(posedge clk);
                #1 ex_fwd = '0;
            end
        join
        finish_test(5, "load-use stall", e0);
        if (n_out - out0 != 1) begin
            $display("Load-use test delivered %0d items on idex instead of one", n_out - out0);
            errors++;
        end

        e0 = errors;
        random_ready = 1;
        for (int i = 0; i < 16; i++) begin
            case (i % 4)
                0: send(with_regs(rand_inst(7'b1100011), 1, 1), $random(seed), '0, '0, '0);
                1: send(with_regs(rand_inst(7'b1100011), 1, 2), $random(seed), '0, '0, '0);
                2: send(rand_inst(7'b1101111), $random(seed), '0, '0, '0);
                default: send(with_regs(rand_inst(7'b1100111), 2, 0), $random(seed), '0, '0, '0);
            endcase
        end
        finish_test(6, "redirect and back-pressure", e0);
        random_ready = 0;

        if (n_in != n_out) begin
            $display("Accepted %0d instructions but %0d left on idex", n_in, n_out);
            errors++;
        end
        $display("tests %0d, accepted %0d, delivered %0d, errors %0d",
                 NUM_TESTS, n_in, n_out, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/cpu_pkg.sv
verilog/control_decoder.sv
verilog/operand_fetch.sv
verilog/id_issue.sv
verilog/decode_top.sv
tb/decode_assertions.sv
tb/tb_decode_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -Wno-fatal \
    --top-module tb_decode_top -f flist.f -o sim_decode
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
